// ==== tb.f ====
+incdir+src
src/rv_pkg.sv
src/instr_decoder.sv
src/reg_file.sv
src/id_ex_stage_reg.sv
src/exec_unit.sv
src/rv_exec_core.sv
test/rv_exec_properties.sv
test/tb_rv_exec_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_exec_core
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_rv_exec_core.sv ====
`timescale 1ns/1ps

module tb_rv_exec_core;

    localparam int PROG_LEN = 33;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 4 + 50;

    logic        clk_i;
    logic        reset_i;
    logic        busywait_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic        instr_valid_i;
    logic        redirect_o;
    logic [31:0] redirect_pc_o;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;

    logic [31:0] prog [PROG_LEN];
    logic [31:0] model_regs [32];
    logic [36:0] exp_q [$]; // {rd, data}.
    logic [15:0] lfsr_state;
    logic [31:0] fetch_pc;
    logic        br_pending;
    logic        exp_taken;
    logic [31:0] exp_target;
    logic        done;
    int          cycles = 0;

    rv_exec_core dut_i (
        .clk_i(clk_i), .reset_i(reset_i), .busywait_i(busywait_i),
        .instr_i(instr_i), .pc_i(pc_i), .instr_valid_i(instr_valid_i),
        .redirect_o(redirect_o), .redirect_pc_o(redirect_pc_o),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic load_program();
        prog[0]  = enc_i(12'd5, 5'd0, 3'b000, 5'd1);
        prog[1]  = enc_i(12'hffd, 5'd0, 3'b000, 5'd2);
        prog[2]  = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3); // both operands bypassed.
        prog[3]  = enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4);
        prog[4]  = {20'habcde, 5'd5, 7'b0110111};
        prog[5]  = {20'h00012, 5'd6, 7'b0010111};
        prog[6]  = enc_i(12'h7ff, 5'd5, 3'b100, 5'd7);
        prog[7]  = enc_i(12'h004, 5'd2, 3'b001, 5'd8);
        prog[8]  = enc_i(12'h401, 5'd2, 3'b101, 5'd9);
        prog[9]  = enc_r(7'h00, 5'd1, 5'd2, 3'b101, 5'd10);
        prog[10] = enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd11);
        prog[11] = enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd12);
        prog[12] = enc_r(7'h00, 5'd1, 5'd5, 3'b110, 5'd13);
        prog[13] = enc_r(7'h00, 5'd2, 5'd5, 3'b111, 5'd14);
        prog[14] = enc_i(12'd7, 5'd1, 3'b000, 5'd0); // write to x0.
        prog[15] = enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd15);
        prog[16] = enc_b(13'd8, 5'd1, 5'd1, 3'b000);
        prog[17] = enc_i(12'd99, 5'd0, 3'b000, 5'd16);
        prog[18] = enc_b(13'd8, 5'd1, 5'd1, 3'b001);
        prog[19] = enc_b(13'd8, 5'd1, 5'd2, 3'b100);
        prog[20] = enc_i(12'd1, 5'd0, 3'b000, 5'd16);
        prog[21] = enc_b(13'd8, 5'd1, 5'd2, 3'b111);
        prog[22] = enc_i(12'd2, 5'd0, 3'b000, 5'd16);
        prog[23] = enc_b(13'd8, 5'd1, 5'd2, 3'b110);
        prog[24] = enc_b(13'd8, 5'd1, 5'd2, 3'b101);
        prog[25] = {1'b0, 10'd4, 1'b0, 8'd0, 5'd17, 7'b1101111}; // jal x17, +8.
        prog[26] = enc_i(12'd1, 5'd0, 3'b000, 5'd16);
        prog[27] = 32'hffffffff;
        prog[28] = 32'h00002003; // unsupported load.
        prog[29] = enc_i(12'd200, 5'd17, 3'b010, 5'd18);
        prog[30] = enc_i(12'd12, 5'd5, 3'b101, 5'd19);
        prog[31] = enc_r(7'h20, 5'd1, 5'd2, 3'b101, 5'd20);
        prog[32] = enc_i(12'h0ff, 5'd2, 3'b111, 5'd21);
    endtask

    task automatic fail_now(input string why);
        $display("error: %s at cycle %0d", why, cycles);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
        fail_now("value mismatch");
    endtask

    task automatic model_exec(input logic [31:0] instr, input logic [31:0] pc);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic        wr;
        opc = instr[6:0];
        f3 = instr[14:12];
        rd = instr[11:7];
        a = model_regs[instr[19:15]];
        b = model_regs[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        wr = 1'b1;
        res = '0;
        case (opc)
            7'b0110011: res = alu_ref(f3, instr[30], a, b);
            7'b0010011: res = alu_ref(f3, instr[30] && f3 == 3'b101, a, imm_i);
            7'b0110111: res = {instr[31:12], 12'b0};
            7'b0010111: res = pc + {instr[31:12], 12'b0};
            7'b1101111: begin
                res = pc + 32'd4;
                br_pending = 1'b1;
                exp_taken = 1'b1;
                exp_target = pc + {{12{instr[31]}}, instr[19:12], instr[20],
                                   instr[30:21], 1'b0};
            end
            7'b1100011: begin
                wr = 1'b0;
                br_pending = 1'b1;
                exp_taken = branch_ref(f3, a, b);
                exp_target = pc + {{20{instr[31]}}, instr[7], instr[30:25],
                                   instr[11:8], 1'b0};
            end
            default: wr = 1'b0;
        endcase
        if (wr) begin
            exp_q.push_back({rd, res});
            if (rd != 5'd0) begin
                model_regs[rd] = res;
            end
        end
    endtask

    task automatic check_cycle();
        logic [36:0] exp;
        if (wb_valid_o && !busywait_i) begin
            if (exp_q.size() == 0) begin
                fail_now("writeback with no instruction expected");
            end else begin
                exp = exp_q.pop_front();
                assert (wb_rd_o == exp[36:32])
                    else report_mismatch("wb_rd_o", 32'(wb_rd_o), 32'(exp[36:32]));
                assert (wb_data_o == exp[31:0])
                    else report_mismatch("wb_data_o", wb_data_o, exp[31:0]);
            end
        end
        if (dut_i.u_props.err_count != 0) begin
            fail_now("a pipeline property failed");
        end
        if (br_pending) begin
            assert (redirect_o == exp_taken)
                else report_mismatch("redirect_o", 32'(redirect_o), 32'(exp_taken));
            if (exp_taken) begin
                assert (redirect_pc_o == exp_target)
                    else report_mismatch("redirect_pc_o", redirect_pc_o, exp_target);
            end
        end else begin
            assert (!redirect_o) else report_mismatch("redirect_o", 32'd1, 32'd0);
        end
        if (!busywait_i) begin
            if (br_pending && exp_taken) begin
                fetch_pc = exp_target; // slot in decode is squashed.
                br_pending = 1'b0;
            end else begin
                br_pending = 1'b0;
                if (instr_valid_i) begin
                    model_exec(instr_i, pc_i);
                    fetch_pc = pc_i + 32'd4;
                end
            end
        end
        done = fetch_pc >= 32'(PROG_LEN * 4) && exp_q.size() == 0 && !br_pending;
    endtask

    task automatic drive_inputs();
        logic stalled;
        int   idx;
        stalled = busywait_i;
        busywait_i = lfsr_bit() & lfsr_bit();
        if (!stalled) begin // fetch holds during a stall.
            idx = int'(fetch_pc >> 2);
            pc_i = fetch_pc;
            if (fetch_pc < 32'(PROG_LEN * 4)) begin
                instr_i = prog[idx];
                instr_valid_i = lfsr_bit() | lfsr_bit();
            end else begin
                instr_i = '0;
                instr_valid_i = 1'b0;
            end
        end
    endtask

    initial begin
        reset_i = 1'b1;
        busywait_i = 1'b0;
        instr_i = '0;
        pc_i = '0;
        instr_valid_i = 1'b0;
        lfsr_state = 16'd54650;
        fetch_pc = '0;
        br_pending = 1'b0;
        exp_taken = 1'b0;
        exp_target = '0;
        done = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        load_program();
        repeat (2) @(posedge clk_i);
        #2;
        reset_i = 1'b0;
        drive_inputs();
        while (!done) begin
            @(negedge clk_i);
            check_cycle();
            if (!done) begin
                @(posedge clk_i);
                #2;
                drive_inputs();
            end
        end
        if (dut_i.u_props.err_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            fail_now("a pipeline property failed");
        end
    end

    initial begin
        while (cycles <= TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        fail_now("timeout, program did not retire");
    end

endmodule

// ==== test/rv_exec_properties.sv ====
`timescale 1ns/1ps

module rv_exec_properties (
    input logic             clk_i,
    input logic             reset_i,
    input logic             busywait_i,
    input logic             redirect_o,
    input rv_pkg::word_t    redirect_pc_o,
    input logic             wb_valid_o,
    input rv_pkg::reg_idx_t wb_rd_o,
    input rv_pkg::word_t    wb_data_o
);
    int   err_count = 0;
    logic squash_pending; // flushed slot heading for ex/wb.

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            squash_pending <= 1'b0;
        end else if (!busywait_i) begin
            squash_pending <= redirect_o;
        end
    end

    assert property (@(posedge clk_i) reset_i |=> !wb_valid_o && !redirect_o)
        else begin
            err_count++;
            $error("outputs active after reset");
        end

    assert property (@(posedge clk_i) disable iff (reset_i)
        busywait_i |=> $stable(wb_valid_o) && $stable(wb_rd_o) && $stable(wb_data_o)
                       && $stable(redirect_o) && $stable(redirect_pc_o))
        else begin
            err_count++;
            $error("outputs changed during a stall");
        end

    assert property (@(posedge clk_i) disable iff (reset_i)
        squash_pending && !busywait_i |=> !wb_valid_o)
        else begin
            err_count++;
            $error("squashed instruction wrote back");
        end

endmodule

bind rv_exec_core rv_exec_properties u_props (.*);

// ==== src/rv_exec_core.sv ====
`timescale 1ns/1ps

module rv_exec_core (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             busywait_i,
    input  rv_pkg::word_t    instr_i,
    input  rv_pkg::word_t    pc_i,
    input  logic             instr_valid_i,
    output logic             redirect_o,
    output rv_pkg::word_t    redirect_pc_o,
    output logic             wb_valid_o,
    output rv_pkg::reg_idx_t wb_rd_o,
    output rv_pkg::word_t    wb_data_o
);
    import rv_pkg::*;

    reg_idx_t    dec_rs1, dec_rs2, dec_rd;
    word_t       dec_imm;
    alu_op_t     dec_alu_op;
    op1_sel_t    dec_op1_sel;
    op2_sel_t    dec_op2_sel;
    branch_sel_t dec_branch_sel;
    wb_sel_t     dec_wb_sel;
    logic        dec_wb_en;
    logic        dec_illegal;

    word_t       rf_rs1_data, rf_rs2_data;

    word_t       ex_pc, ex_rs1_value, ex_rs2_value, ex_imm;
    alu_op_t     ex_alu_op;
    op1_sel_t    ex_op1_sel;
    op2_sel_t    ex_op2_sel;
    branch_sel_t ex_branch_sel;
    wb_sel_t     ex_wb_sel;
    logic        ex_wb_en;
    reg_idx_t    ex_rd, ex_rs1_label, ex_rs2_label;

    logic        id_valid;
    logic        id_flush;
    logic        rf_we;

    assign id_valid = instr_valid_i && !dec_illegal;
    assign id_flush = redirect_o && !busywait_i; // stalled branch stays in execute.
    assign rf_we    = wb_valid_o && !busywait_i; // one write per retired result.

    instr_decoder u_decoder (
        .instr_i(instr_i), .rs1_o(dec_rs1), .rs2_o(dec_rs2), .rd_o(dec_rd),
        .imm_o(dec_imm), .alu_op_o(dec_alu_op), .op1_sel_o(dec_op1_sel),
        .op2_sel_o(dec_op2_sel), .branch_sel_o(dec_branch_sel), .wb_sel_o(dec_wb_sel),
        .reg_wb_en_o(dec_wb_en), .illegal_o(dec_illegal)
    );

    reg_file u_reg_file (
        .clk_i(clk_i), .reset_i(reset_i),
        .rs1_i(dec_rs1), .rs2_i(dec_rs2),
        .rs1_data_o(rf_rs1_data), .rs2_data_o(rf_rs2_data),
        .we_i(rf_we), .rd_i(wb_rd_o), .wd_i(wb_data_o)
    );

    id_ex_stage_reg u_id_ex (
        .clk_i(clk_i), .reset_i(reset_i), .busywait_i(busywait_i),
        .flush_i(id_flush), .valid_i(id_valid),
        .pc_i(pc_i), .rs1_value_i(rf_rs1_data), .rs2_value_i(rf_rs2_data),
        .imm_i(dec_imm), .alu_op_i(dec_alu_op), .op1_sel_i(dec_op1_sel),
        .op2_sel_i(dec_op2_sel), .branch_sel_i(dec_branch_sel), .wb_sel_i(dec_wb_sel),
        .reg_wb_en_i(dec_wb_en), .rd_i(dec_rd),
        .rs1_label_i(dec_rs1), .rs2_label_i(dec_rs2),
        .pc_o(ex_pc), .rs1_value_o(ex_rs1_value), .rs2_value_o(ex_rs2_value),
        .imm_o(ex_imm), .alu_op_o(ex_alu_op), .op1_sel_o(ex_op1_sel),
        .op2_sel_o(ex_op2_sel), .branch_sel_o(ex_branch_sel), .wb_sel_o(ex_wb_sel),
        .reg_wb_en_o(ex_wb_en), .rd_o(ex_rd),
        .rs1_label_o(ex_rs1_label), .rs2_label_o(ex_rs2_label)
    );

    exec_unit u_exec (
        .clk_i(clk_i), .reset_i(reset_i), .busywait_i(busywait_i),
        .pc_i(ex_pc), .rs1_value_i(ex_rs1_value), .rs2_value_i(ex_rs2_value),
        .imm_i(ex_imm), .alu_op_i(ex_alu_op), .op1_sel_i(ex_op1_sel),
        .op2_sel_i(ex_op2_sel), .branch_sel_i(ex_branch_sel), .wb_sel_i(ex_wb_sel),
        .reg_wb_en_i(ex_wb_en), .rd_i(ex_rd),
        .rs1_label_i(ex_rs1_label), .rs2_label_i(ex_rs2_label),
        .redirect_o(redirect_o), .redirect_pc_o(redirect_pc_o),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
    );

endmodule

// ==== src/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                busywait_i,

    input  rv_pkg::word_t       pc_i,
    input  rv_pkg::word_t       rs1_value_i,
    input  rv_pkg::word_t       rs2_value_i,
    input  rv_pkg::word_t       imm_i,
    input  rv_pkg::alu_op_t     alu_op_i,
    input  rv_pkg::op1_sel_t    op1_sel_i,
    input  rv_pkg::op2_sel_t    op2_sel_i,
    input  rv_pkg::branch_sel_t branch_sel_i,
    input  rv_pkg::wb_sel_t     wb_sel_i,
    input  logic                reg_wb_en_i,
    input  rv_pkg::reg_idx_t    rd_i,
    input  rv_pkg::reg_idx_t    rs1_label_i,
    input  rv_pkg::reg_idx_t    rs2_label_i,

    output logic                redirect_o,
    output rv_pkg::word_t       redirect_pc_o,
    output logic                wb_valid_o,
    output rv_pkg::reg_idx_t    wb_rd_o,
    output rv_pkg::word_t       wb_data_o
);
    import rv_pkg::*;

    word_t rs1_fwd;
    word_t rs2_fwd;
    word_t op_a;
    word_t op_b;
    word_t alu_result;
    word_t result;
    logic  taken;

    // bypass the older result still sitting in ex/wb.
    assign rs1_fwd = (wb_valid_o && wb_rd_o != '0 && wb_rd_o == rs1_label_i) ?
                     wb_data_o : rs1_value_i;
    assign rs2_fwd = (wb_valid_o && wb_rd_o != '0 && wb_rd_o == rs2_label_i) ?
                     wb_data_o : rs2_value_i;

    assign op_a = (op1_sel_i == OP1_PC) ? pc_i : rs1_fwd;
    assign op_b = (op2_sel_i == OP2_IMM) ? imm_i : rs2_fwd;

    always_comb begin
        case (alu_op_i)
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLL:    alu_result = op_a << op_b[4:0];
            ALU_SLT:    alu_result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_result = word_t'(op_a < op_b);
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SRL:    alu_result = op_a >> op_b[4:0];
            ALU_SRA:    alu_result = $signed(op_a) >>> op_b[4:0];
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    always_comb begin
        case (branch_sel_i)
            BR_EQ:   taken = rs1_fwd == rs2_fwd;
            BR_NE:   taken = rs1_fwd != rs2_fwd;
            BR_LT:   taken = $signed(rs1_fwd) < $signed(rs2_fwd);
            BR_GE:   taken = $signed(rs1_fwd) >= $signed(rs2_fwd);
            BR_LTU:  taken = rs1_fwd < rs2_fwd;
            BR_GEU:  taken = rs1_fwd >= rs2_fwd;
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0; // bubble or plain op.
        endcase
    end

    assign redirect_o    = taken;
    assign redirect_pc_o = pc_i + imm_i;

    assign result = (wb_sel_i == WB_PC_PLUS4) ? pc_i + word_t'(4) : alu_result;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_valid_o <= 1'b0;
            wb_rd_o    <= '0;
            wb_data_o  <= '0;
        end else if (!busywait_i) begin
            wb_valid_o <= reg_wb_en_i;
            wb_rd_o    <= rd_i;
            wb_data_o  <= result;
        end
    end

endmodule

// ==== src/id_ex_stage_reg.sv ====
`timescale 1ns/1ps

module id_ex_stage_reg (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                busywait_i,
    input  logic                flush_i,
    input  logic                valid_i,

    input  rv_pkg::word_t       pc_i,
    input  rv_pkg::word_t       rs1_value_i,
    input  rv_pkg::word_t       rs2_value_i,
    input  rv_pkg::word_t       imm_i,
    input  rv_pkg::alu_op_t     alu_op_i,
    input  rv_pkg::op1_sel_t    op1_sel_i,
    input  rv_pkg::op2_sel_t    op2_sel_i,
    input  rv_pkg::branch_sel_t branch_sel_i,
    input  rv_pkg::wb_sel_t     wb_sel_i,
    input  logic                reg_wb_en_i,
    input  rv_pkg::reg_idx_t    rd_i,
    input  rv_pkg::reg_idx_t    rs1_label_i,
    input  rv_pkg::reg_idx_t    rs2_label_i,

    output rv_pkg::word_t       pc_o,
    output rv_pkg::word_t       rs1_value_o,
    output rv_pkg::word_t       rs2_value_o,
    output rv_pkg::word_t       imm_o,
    output rv_pkg::alu_op_t     alu_op_o,
    output rv_pkg::op1_sel_t    op1_sel_o,
    output rv_pkg::op2_sel_t    op2_sel_o,
    output rv_pkg::branch_sel_t branch_sel_o,
    output rv_pkg::wb_sel_t     wb_sel_o,
    output logic                reg_wb_en_o,
    output rv_pkg::reg_idx_t    rd_o,
    output rv_pkg::reg_idx_t    rs1_label_o,
    output rv_pkg::reg_idx_t    rs2_label_o
);
    import rv_pkg::*;

    logic load_bubble;

    // flush wins over a stall; an empty slot is captured as a bubble.
    assign load_bubble = reset_i || flush_i || (!busywait_i && !valid_i);

    always_ff @(posedge clk_i) begin
        if (load_bubble) begin
            pc_o         <= '0;
            rs1_value_o  <= '0;
            rs2_value_o  <= '0;
            imm_o        <= '0;
            alu_op_o     <= ALU_ADD;
            op1_sel_o    <= OP1_RS1;
            op2_sel_o    <= OP2_RS2;
            branch_sel_o <= BR_NONE;
            wb_sel_o     <= WB_ALU;
            reg_wb_en_o  <= 1'b0;
            rd_o         <= '0;
            rs1_label_o  <= '0;
            rs2_label_o  <= '0;
        end else if (!busywait_i) begin
            pc_o         <= pc_i;
            rs1_value_o  <= rs1_value_i;
            rs2_value_o  <= rs2_value_i;
            imm_o        <= imm_i;
            alu_op_o     <= alu_op_i;
            op1_sel_o    <= op1_sel_i;
            op2_sel_o    <= op2_sel_i;
            branch_sel_o <= branch_sel_i;
            wb_sel_o     <= wb_sel_i;
            reg_wb_en_o  <= reg_wb_en_i && valid_i;
            rd_o         <= rd_i;
            rs1_label_o  <= rs1_label_i;
            rs2_label_o  <= rs2_label_i;
        end
    end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module reg_file (
    input  logic             clk_i,
    input  logic             reset_i,
    input  rv_pkg::reg_idx_t rs1_i,
    input  rv_pkg::reg_idx_t rs2_i,
    output rv_pkg::word_t    rs1_data_o,
    output rv_pkg::word_t    rs2_data_o,
    input  logic             we_i,
    input  rv_pkg::reg_idx_t rd_i,
    input  rv_pkg::word_t    wd_i
);
    import rv_pkg::*;

    word_t regs [`RV_NUM_REGS];
    logic  wr_live;

    assign wr_live = we_i && rd_i != '0; // x0 never written.

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[rd_i] <= wd_i;
        end
    end

    // same-cycle write shows through.
    assign rs1_data_o = (wr_live && rd_i == rs1_i) ? wd_i : regs[rs1_i];
    assign rs2_data_o = (wr_live && rd_i == rs2_i) ? wd_i : regs[rs2_i];

endmodule

// ==== src/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  rv_pkg::word_t       instr_i,
    output rv_pkg::reg_idx_t    rs1_o,
    output rv_pkg::reg_idx_t    rs2_o,
    output rv_pkg::reg_idx_t    rd_o,
    output rv_pkg::word_t       imm_o,
    output rv_pkg::alu_op_t     alu_op_o,
    output rv_pkg::op1_sel_t    op1_sel_o,
    output rv_pkg::op2_sel_t    op2_sel_o,
    output rv_pkg::branch_sel_t branch_sel_o,
    output rv_pkg::wb_sel_t     wb_sel_o,
    output logic                reg_wb_en_o,
    output logic                illegal_o
);
    import rv_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       bad_funct7;
    word_t      imm_i_type;
    word_t      imm_u_type;
    word_t      imm_b_type;
    word_t      imm_j_type;
    alu_op_t    arith_op;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rd_o   = instr_i[11:7];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];

    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_b_type = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    // bit 30 selects sub/sra, but addi must ignore it.
    assign alt = instr_i[30] && (opcode == OPC_OP || funct3 == 3'b101);

    // only sub, sra and srai may set funct7[5].
    assign bad_funct7 = funct7 != 7'b0000000 &&
                        !(funct7 == 7'b0100000 && (funct3 == 3'b101 ||
                          (funct3 == 3'b000 && opcode == OPC_OP)));

    always_comb begin
        case (funct3)
            3'b000:  arith_op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        alu_op_o     = ALU_ADD;
        op1_sel_o    = OP1_RS1;
        op2_sel_o    = OP2_RS2;
        branch_sel_o = BR_NONE;
        wb_sel_o     = WB_ALU;
        reg_wb_en_o  = 1'b0;
        imm_o        = '0;
        illegal_o    = 1'b0;
        case (opcode)
            OPC_OP: begin
                alu_op_o    = arith_op;
                reg_wb_en_o = 1'b1;
                illegal_o   = bad_funct7;
            end
            OPC_OP_IMM: begin
                alu_op_o    = arith_op;
                op2_sel_o   = OP2_IMM;
                imm_o       = imm_i_type;
                reg_wb_en_o = 1'b1;
                illegal_o   = (funct3 == 3'b001 || funct3 == 3'b101) && bad_funct7;
            end
            OPC_LUI: begin
                alu_op_o    = ALU_PASS_B;
                op2_sel_o   = OP2_IMM;
                imm_o       = imm_u_type;
                reg_wb_en_o = 1'b1;
            end
            OPC_AUIPC: begin
                op1_sel_o   = OP1_PC;
                op2_sel_o   = OP2_IMM;
                imm_o       = imm_u_type;
                reg_wb_en_o = 1'b1;
            end
            OPC_JAL: begin
                imm_o        = imm_j_type;
                branch_sel_o = BR_JAL;
                wb_sel_o     = WB_PC_PLUS4; // link value.
                reg_wb_en_o  = 1'b1;
            end
            OPC_BRANCH: begin
                imm_o        = imm_b_type;
                branch_sel_o = branch_sel_t'(funct3);
                illegal_o    = funct3 == 3'b010 || funct3 == 3'b011;
            end
            default: illegal_o = 1'b1;
        endcase
        if (illegal_o) begin
            reg_wb_en_o  = 1'b0; // behaves as a bubble.
            branch_sel_o = BR_NONE;
        end
    end

endmodule

// ==== src/rv_pkg.sv ====
`include "rv_config.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10 // lui result.
    } alu_op_t;

    typedef enum logic {
        OP1_RS1 = 1'b0,
        OP1_PC  = 1'b1
    } op1_sel_t;

    typedef enum logic {
        OP2_RS2 = 1'b0,
        OP2_IMM = 1'b1
    } op2_sel_t;

    // conditional codes follow the branch funct3 field.
    typedef enum logic [2:0] {
        BR_EQ   = 3'b000,
        BR_NE   = 3'b001,
        BR_NONE = 3'b010, // bubble.
        BR_JAL  = 3'b011,
        BR_LT   = 3'b100,
        BR_GE   = 3'b101,
        BR_LTU  = 3'b110,
        BR_GEU  = 3'b111
    } branch_sel_t;

    typedef enum logic {
        WB_ALU      = 1'b0,
        WB_PC_PLUS4 = 1'b1
    } wb_sel_t;

endpackage

// ==== src/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data path and address width in bits.
`define RV_XLEN 32

// architectural integer registers, x0 included.
`define RV_NUM_REGS 32

`endif
